// File: src/vid_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vid_pkg: shared video mode, widths, register numbers and
// XR register map for the tile/bitmap video core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package vid_pkg;

    // reduced mode, sized for simulation
    localparam int H_VISIBLE = 64;     // active pixels per line
    localparam int H_FRONT   = 4;      // front porch clocks
    localparam int H_SYNC    = 8;      // hsync pulse clocks
    localparam int H_BACK    = 4;      // back porch clocks
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

    localparam int V_VISIBLE = 48;     // active lines per frame
    localparam int V_FRONT   = 2;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 4;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    // data path widths
    localparam int COUNT_W   = 11;     // h and v counters
    localparam int WORD_W    = 16;     // host register and XR word
    localparam int COLOR_W   = 12;     // 4:4:4 RGB
    localparam int PAL_IDX_W = 8;      // 256 palette entries

    // colour bars are 2**BAR_SHIFT pixels wide
    localparam int BAR_SHIFT = 3;

    // interrupt sources
    localparam int INTR_W      = 2;
    localparam int INTR_VBLANK = 0;    // start of vertical blank
    localparam int INTR_LINE   = 1;    // scanline compare hit

    // XR space at/above this is palette, low 8 bits index it
    localparam logic [WORD_W-1:0] XR_PAL_BASE = 16'h8000;

    // XR video registers below the palette
    typedef enum logic [WORD_W-1:0] {
        XR_VID_BASE = 16'h0000,        // palette index base
        XR_LINE_CMP = 16'h0001         // line interrupt compare
    } xr_reg_t;

    // host register numbers
    typedef enum logic [3:0] {
        REG_XR_ADDR   = 4'h0,          // XR address
        REG_XR_DATA   = 4'h1,          // XR data, addr auto-increments
        REG_INTR_MASK = 4'h2,          // interrupt enables
        REG_INTR_CLR  = 4'h3,          // wr clears, rd returns status
        REG_SCANLINE  = 4'h4           // read only current line
    } bus_reg_t;

endpackage

// File: src/bus_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus_regs: 8-bit host bus to 16-bit word registers, XR
// indirect access with auto-increment, and byte readback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module bus_regs (
    input  wire logic                        clk,
    input  wire logic                        reset_i,
    input  wire logic                        bus_cs_n_i,     // one clock strobe, active low
    input  wire logic                        bus_rd_nwr_i,   // 0 = write, 1 = read
    input  wire logic [3:0]                  bus_reg_num_i,  // register number
    input  wire logic                        bus_bytesel_i,  // 0 = high byte, 1 = low byte
    input  wire logic [7:0]                  bus_data_i,
    input  wire logic [vid_pkg::INTR_W-1:0]  intr_status_i,  // pending status for readback
    input  wire logic [vid_pkg::COUNT_W-1:0] v_count_i,      // current scanline
    output      logic [7:0]                  bus_data_o,
    output      logic                        pal_wr_o,       // palette write strobe
    output      logic                        vid_reg_wr_o,   // video register write strobe
    output      logic [vid_pkg::WORD_W-1:0]  xr_addr_o,
    output      logic [vid_pkg::WORD_W-1:0]  xr_data_o,
    output      logic [vid_pkg::INTR_W-1:0]  intr_mask_o,
    output      logic [vid_pkg::INTR_W-1:0]  intr_clr_o      // one cycle clear vector
);
    import vid_pkg::*;

    bus_reg_t           reg_num;        // decoded register number
    logic               bus_wr;
    logic               bus_rd;
    logic               commit;         // low byte write completes the word
    logic [7:0]         hi_byte_q;      // even byte held until odd arrives
    logic [WORD_W-1:0]  wr_word;
    logic [WORD_W-1:0]  rd_word;
    logic [WORD_W-1:0]  xr_addr_q;
    logic [WORD_W-1:0]  xr_addr_nxt;    // addr after a pending increment
    logic               xr_is_pal;

    assign reg_num = bus_reg_t'(bus_reg_num_i);
    assign bus_wr  = !bus_cs_n_i && !bus_rd_nwr_i;
    assign bus_rd  = !bus_cs_n_i && bus_rd_nwr_i;
    assign commit  = bus_wr && bus_bytesel_i;
    assign wr_word = {hi_byte_q, bus_data_i};

    // a strobe in flight means the addr is about to step
    assign xr_addr_nxt = (pal_wr_o || vid_reg_wr_o) ? xr_addr_q + 1'b1 : xr_addr_q;
    assign xr_is_pal   = xr_addr_nxt >= XR_PAL_BASE;
    assign xr_addr_o   = xr_addr_q;             // valid with the write strobe

    // high byte latch
    always_ff @(posedge clk) begin
        if (bus_wr && !bus_bytesel_i) begin
            hi_byte_q <= bus_data_i;
        end
    end

    // XR write data, stays put for the strobe cycle
    always_ff @(posedge clk) begin
        if (commit && reg_num == REG_XR_DATA) begin
            xr_data_o <= wr_word;
        end
    end

    // word commits
    always_ff @(posedge clk) begin
        if (reset_i) begin
            xr_addr_q    <= '0;
            pal_wr_o     <= 1'b0;
            vid_reg_wr_o <= 1'b0;
            intr_mask_o  <= '0;
            intr_clr_o   <= '0;
        end else begin
            pal_wr_o     <= 1'b0;               // strobes last one cycle
            vid_reg_wr_o <= 1'b0;
            intr_clr_o   <= '0;

            // step XR addr the edge after a data commit
            if (pal_wr_o || vid_reg_wr_o) begin
                xr_addr_q <= xr_addr_q + 1'b1;
            end

            if (commit) begin
                case (reg_num)
                    REG_XR_ADDR: begin
                        xr_addr_q <= wr_word;   // new addr beats the increment
                    end
                    REG_XR_DATA: begin
                        pal_wr_o     <= xr_is_pal;      // steer by XR region
                        vid_reg_wr_o <= !xr_is_pal;
                    end
                    REG_INTR_MASK: begin
                        intr_mask_o <= wr_word[INTR_W-1:0];
                    end
                    REG_INTR_CLR: begin
                        intr_clr_o <= wr_word[INTR_W-1:0];  // write 1 to clear
                    end
                    default: begin
                        // unused numbers ignored
                    end
                endcase
            end
        end
    end

    // readback word select
    always_comb begin
        rd_word = '0;                           // unused regs read as zero
        case (reg_num)
            REG_INTR_MASK: rd_word[INTR_W-1:0]  = intr_mask_o;
            REG_INTR_CLR:  rd_word[INTR_W-1:0]  = intr_status_i;
            REG_SCANLINE:  rd_word[COUNT_W-1:0] = v_count_i;
            default:       rd_word = '0;
        endcase
    end

    // byte out, held until the next read
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bus_data_o <= 8'h00;
        end else if (bus_rd) begin
            bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
        end
    end

endmodule

`default_nettype wire

// File: src/palette_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// palette_ram: 256 x 12-bit dual-port colour lookup
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module palette_ram (
    input  wire logic                          clk,
    input  wire logic                          wr_i,       // host side write
    input  wire logic [vid_pkg::PAL_IDX_W-1:0] wr_idx_i,
    input  wire logic [vid_pkg::COLOR_W-1:0]   wr_rgb_i,   // 4:4:4 colour
    input  wire logic [vid_pkg::PAL_IDX_W-1:0] rd_idx_i,   // video side lookup
    output      logic [vid_pkg::COLOR_W-1:0]   pal_rgb_o
);
    import vid_pkg::*;

    logic [COLOR_W-1:0] mem [2**PAL_IDX_W];    // maps to one block RAM

    // write port
    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_idx_i] <= wr_rgb_i;
        end
    end

    // read port, one clock latency
    always_ff @(posedge clk) begin
        pal_rgb_o <= mem[rd_idx_i];
    end

endmodule

`default_nettype wire

// File: src/video_timing.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video_timing: h/v counters, sync and blank, colour-bar
// palette index, XR video registers and RGB output stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module video_timing (
    input  wire logic                          clk,
    input  wire logic                          reset_i,
    input  wire logic                          vid_reg_wr_i,   // XR video reg strobe
    input  wire logic [vid_pkg::WORD_W-1:0]    xr_addr_i,
    input  wire logic [vid_pkg::WORD_W-1:0]    xr_data_i,
    input  wire logic [vid_pkg::COLOR_W-1:0]   pal_rgb_i,      // palette lookup result
    output      logic [vid_pkg::PAL_IDX_W-1:0] pal_idx_o,
    output      logic [vid_pkg::COUNT_W-1:0]   v_count_o,
    output      logic [vid_pkg::INTR_W-1:0]    intr_signal_o,  // one cycle event pulses
    output      logic [3:0]                    red_o,
    output      logic [3:0]                    green_o,
    output      logic [3:0]                    blue_o,
    output      logic                          hsync_o,
    output      logic                          vsync_o,
    output      logic                          dv_de_o
);
    import vid_pkg::*;

    logic [COUNT_W-1:0]   h_count;
    logic [COUNT_W-1:0]   v_count;
    logic [COUNT_W-1:0]   v_next;          // line number after this one
    logic [COUNT_W-1:0]   bar_col;         // bar number across the line
    logic                 h_last;          // last clock of the line
    logic                 de_0;            // stage 0, straight from counters
    logic                 hs_0;
    logic                 vs_0;
    logic [1:0]           de_pipe;         // [0] lines up with index, [1] with RGB
    logic [1:0]           hs_pipe;
    logic [1:0]           vs_pipe;
    logic [PAL_IDX_W-1:0] vid_base_q;      // XR_VID_BASE
    logic [COUNT_W-1:0]   line_cmp_q;      // XR_LINE_CMP
    logic [PAL_IDX_W-1:0] pal_idx_q;

    assign h_last = h_count == COUNT_W'(H_TOTAL - 1);
    assign v_next = (v_count == COUNT_W'(V_TOTAL - 1)) ? '0 : v_count + 1'b1;

    // pixel and line counters, free running
    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_last) begin
            h_count <= '0;
            v_count <= v_next;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // regions: visible, front porch, sync, back porch
    always_comb begin
        de_0 = (h_count < COUNT_W'(H_VISIBLE)) && (v_count < COUNT_W'(V_VISIBLE));
        hs_0 = (h_count >= COUNT_W'(H_VISIBLE + H_FRONT)) &&
               (h_count <  COUNT_W'(H_VISIBLE + H_FRONT + H_SYNC));
        vs_0 = (v_count >= COUNT_W'(V_VISIBLE + V_FRONT)) &&
               (v_count <  COUNT_W'(V_VISIBLE + V_FRONT + V_SYNC));
    end

    // XR video registers
    always_ff @(posedge clk) begin
        if (reset_i) begin
            vid_base_q <= '0;
            line_cmp_q <= '0;
        end else if (vid_reg_wr_i) begin
            case (xr_reg_t'(xr_addr_i))
                XR_VID_BASE: vid_base_q <= xr_data_i[PAL_IDX_W-1:0];
                XR_LINE_CMP: line_cmp_q <= xr_data_i[COUNT_W-1:0];
                default: begin
                    // no other video regs
                end
            endcase
        end
    end

    // events flagged at end of line, so the pulse is on clock 0 of the new one
    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_signal_o <= '0;
        end else begin
            intr_signal_o <= '0;
            if (h_last) begin
                intr_signal_o[INTR_VBLANK] <= v_next == COUNT_W'(V_VISIBLE);
                intr_signal_o[INTR_LINE]   <= v_next == line_cmp_q;
            end
        end
    end

    // colour-bar index, base + column / bar width
    assign bar_col = h_count >> BAR_SHIFT;

    always_ff @(posedge clk) begin
        pal_idx_q <= vid_base_q + bar_col[PAL_IDX_W-1:0];   // wraps mod 256
    end

    assign pal_idx_o = pal_idx_q;

    // delay syncs and enable by index reg + RAM read
    always_ff @(posedge clk) begin
        if (reset_i) begin
            de_pipe <= '0;
            hs_pipe <= '0;
            vs_pipe <= '0;
        end else begin
            de_pipe <= {de_pipe[0], de_0};
            hs_pipe <= {hs_pipe[0], hs_0};
            vs_pipe <= {vs_pipe[0], vs_0};
        end
    end

    assign dv_de_o   = de_pipe[1];
    assign hsync_o   = hs_pipe[1];
    assign vsync_o   = vs_pipe[1];
    assign v_count_o = v_count;

    // black outside the visible area
    assign {red_o, green_o, blue_o} = dv_de_o ? pal_rgb_i : '0;

endmodule

`default_nettype wire

// File: src/intr_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// intr_ctrl: pending interrupt status and bus interrupt strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module intr_ctrl (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic [vid_pkg::INTR_W-1:0] intr_signal_i,  // event pulses from video
    input  wire logic [vid_pkg::INTR_W-1:0] intr_mask_i,    // 1 = enabled
    input  wire logic [vid_pkg::INTR_W-1:0] intr_clr_i,     // 1 = clear pending
    output      logic [vid_pkg::INTR_W-1:0] intr_status_o,
    output      logic                       bus_intr_o      // one cycle to the host
);
    import vid_pkg::*;

    logic [INTR_W-1:0] intr_new;   // enabled events not yet pending

    assign intr_new = intr_signal_i & intr_mask_i & ~intr_status_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_status_o <= '0;
            bus_intr_o    <= 1'b0;
        end else begin
            bus_intr_o    <= |intr_new;
            // set on event, clear wins when both land together
            intr_status_o <= (intr_status_o | intr_signal_i) & ~intr_clr_i;
        end
    end

endmodule

`default_nettype wire

// File: src/vid_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vid_top: video core top, host registers, palette, timing
// and interrupt blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module vid_top (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       bus_cs_n_i,      // register strobe, active low
    input  wire logic       bus_rd_nwr_i,    // 0 = write, 1 = read
    input  wire logic [3:0] bus_reg_num_i,
    input  wire logic       bus_bytesel_i,   // 0 = high byte, 1 = low byte
    input  wire logic [7:0] bus_data_i,
    output      logic [7:0] bus_data_o,
    output      logic       bus_intr_o,      // interrupt strobe to host
    output      logic [3:0] red_o,
    output      logic [3:0] green_o,
    output      logic [3:0] blue_o,
    output      logic       hsync_o,
    output      logic       vsync_o,
    output      logic       dv_de_o          // display enable
);
    import vid_pkg::*;

    logic                 pal_wr;
    logic                 vid_reg_wr;
    logic [WORD_W-1:0]    xr_addr;
    logic [WORD_W-1:0]    xr_data;
    logic [INTR_W-1:0]    intr_mask;
    logic [INTR_W-1:0]    intr_clr;
    logic [INTR_W-1:0]    intr_status;
    logic [INTR_W-1:0]    intr_signal;
    logic [COUNT_W-1:0]   v_count;
    logic [PAL_IDX_W-1:0] pal_idx;
    logic [COLOR_W-1:0]   pal_rgb;

    // host side registers
    bus_regs u_bus_regs (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .intr_status_i (intr_status),
        .v_count_i     (v_count),
        .bus_data_o    (bus_data_o),
        .pal_wr_o      (pal_wr),
        .vid_reg_wr_o  (vid_reg_wr),
        .xr_addr_o     (xr_addr),
        .xr_data_o     (xr_data),
        .intr_mask_o   (intr_mask),
        .intr_clr_o    (intr_clr)
    );

    // palette, indexed by low XR addr bits
    palette_ram u_palette_ram (
        .clk       (clk),
        .wr_i      (pal_wr),
        .wr_idx_i  (xr_addr[PAL_IDX_W-1:0]),
        .wr_rgb_i  (xr_data[COLOR_W-1:0]),
        .rd_idx_i  (pal_idx),
        .pal_rgb_o (pal_rgb)
    );

    video_timing u_video_timing (
        .clk           (clk),
        .reset_i       (reset_i),
        .vid_reg_wr_i  (vid_reg_wr),
        .xr_addr_i     (xr_addr),
        .xr_data_i     (xr_data),
        .pal_rgb_i     (pal_rgb),
        .pal_idx_o     (pal_idx),
        .v_count_o     (v_count),
        .intr_signal_o (intr_signal),
        .red_o         (red_o),
        .green_o       (green_o),
        .blue_o        (blue_o),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .dv_de_o       (dv_de_o)
    );

    intr_ctrl u_intr_ctrl (
        .clk           (clk),
        .reset_i       (reset_i),
        .intr_signal_i (intr_signal),
        .intr_mask_i   (intr_mask),
        .intr_clr_i    (intr_clr),
        .intr_status_o (intr_status),
        .bus_intr_o    (bus_intr_o)
    );

endmodule

`default_nettype wire

// File: testbench/vid_tb_tasks.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host bus tasks for the video core testbench, word writes
// as two byte strobes and byte or word reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef VID_TB_TASKS_SVH
`define VID_TB_TASKS_SVH

// high byte first, low byte commits the word
task automatic bus_write_word(input logic [3:0] reg_num, input logic [15:0] word);
    @(posedge clk);
    bus_cs_n_i    <= 1'b0;
    bus_rd_nwr_i  <= 1'b0;
    bus_reg_num_i <= reg_num;
    bus_bytesel_i <= 1'b0;
    bus_data_i    <= word[15:8];
    @(posedge clk);
    bus_bytesel_i <= 1'b1;          // second strobe, low byte
    bus_data_i    <= word[7:0];
    @(posedge clk);
    bus_cs_n_i    <= 1'b1;
endtask

// data is loaded on the strobe edge, sampled at the falling edge
task automatic bus_read_byte(input logic [3:0] reg_num, input logic sel,
                             output logic [7:0] data);
    @(posedge clk);
    bus_cs_n_i    <= 1'b0;
    bus_rd_nwr_i  <= 1'b1;
    bus_reg_num_i <= reg_num;
    bus_bytesel_i <= sel;
    @(posedge clk);
    bus_cs_n_i    <= 1'b1;
    @(negedge clk);
    data = bus_data_o;
endtask

task automatic bus_read_word(input logic [3:0] reg_num, output logic [15:0] word);
    logic [7:0] hi;
    logic [7:0] lo;
    bus_read_byte(reg_num, 1'b0, hi);
    bus_read_byte(reg_num, 1'b1, lo);
    word = {hi, lo};
endtask

`endif

// File: testbench/vid_top_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vid_top_tb: palette, colour bars, sync geometry and
// interrupt checks for the video core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vid_top_tb;
    import vid_pkg::*;

    localparam int FRAME = H_TOTAL * V_TOTAL;          // clocks per frame
    localparam int LIMIT = 6 * FRAME + 2000;
    localparam int SEED  = 32'h46ef;

    logic        clk;
    logic        reset_i;
    logic        bus_cs_n_i;
    logic        bus_rd_nwr_i;
    logic [3:0]  bus_reg_num_i;
    logic        bus_bytesel_i;
    logic [7:0]  bus_data_i;
    logic [7:0]  bus_data_o;
    logic        bus_intr_o;
    logic [3:0]  red_o;
    logic [3:0]  green_o;
    logic [3:0]  blue_o;
    logic        hsync_o;
    logic        vsync_o;
    logic        dv_de_o;

    logic [11:0] pal_model [256];       // expected palette
    int          base_model;            // expected XR_VID_BASE
    bit          rst_done;
    bit          pix_on;                // pixel compare enabled
    int          cyc;
    int          err_value;
    int          err_other;
    int          intr_count;            // bus_intr_o pulses seen
    int          last_intr_cyc;
    int          col;                   // pixel column, from de rise
    int          hs_len;
    int          vs_len;
    int          de_lines;
    int          last_hs_rise;
    bit          de_q;
    bit          hs_q;
    bit          vs_q;
    bit          vs_seen;

    `include "vid_tb_tasks.svh"

    vid_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input int exp, input int got);
        assert (exp == got) else begin
            err_value++;
            $display("error t=%0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic expect_true(input bit cond, input string msg);
        assert (cond) else begin
            err_other++;
            $display("error t=%0t %s", $time, msg);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // wait for a new bus interrupt, at most about a frame
    task automatic wait_for_intr(input int start, output bit seen);
        int n;
        n = 0;
        while (intr_count == start && n < FRAME + 200) begin
            @(negedge clk);             // pulse count settled by now
            n++;
        end
        seen = intr_count != start;
    endtask

    // sampled before the edge's updates, so values are settled
    always @(posedge clk) begin
        cyc++;
        if (rst_done) begin
            if (bus_intr_o) begin
                intr_count++;
                last_intr_cyc = cyc;
            end
            if (dv_de_o) begin
                if (pix_on)
                    check_value("rgb", pal_model[(base_model + (col >> BAR_SHIFT)) % 256],
                                {red_o, green_o, blue_o});
                if (!de_q) de_lines++;
                col++;
            end else begin
                check_value("rgb blank", 0, {red_o, green_o, blue_o});
                if (de_q) check_value("dv_de_o width", H_VISIBLE, col);
                col = 0;
            end
            if (hsync_o) hs_len++;
            if (hsync_o && !hs_q) begin
                if (last_hs_rise > 0) check_value("hsync period", H_TOTAL, cyc - last_hs_rise);
                last_hs_rise = cyc;
            end
            if (!hsync_o && hs_q) begin
                check_value("hsync width", H_SYNC, hs_len);
                hs_len = 0;
            end
            if (vsync_o) vs_len++;
            if (vsync_o && !vs_q) begin
                if (vs_seen) check_value("visible lines", V_VISIBLE, de_lines);
                vs_seen  = 1'b1;
                de_lines = 0;
            end
            if (!vsync_o && vs_q) begin
                check_value("vsync width", V_SYNC * H_TOTAL, vs_len);
                vs_len = 0;
            end
            de_q = dv_de_o;
            hs_q = hsync_o;
            vs_q = vsync_o;
        end
    end

    // run limit
    initial begin
        while (cyc < LIMIT) @(posedge clk);
        $display("timeout: run passed %0d cycles without finishing", LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [15:0] w;
        logic [11:0] color;
        bit          seen;
        int          n0;
        int          p1;
        void'($urandom(SEED));
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b0;
        bus_reg_num_i = 4'h0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = 8'h00;

        // outputs quiet in reset and the cycle after
        for (int i = 0; i < 9; i++) begin
            @(posedge clk);
            if (i == 7) reset_i <= 1'b0;    // 8th rising edge still sees reset high
            @(negedge clk);
            expect_true(!bus_intr_o && !hsync_o && !vsync_o && !dv_de_o, "output high in reset");
            check_value("rgb in reset", 0, {red_o, green_o, blue_o});
        end
        rst_done = 1'b1;
        bus_read_word(REG_INTR_MASK, w);
        check_value("intr mask", 0, w);
        bus_read_word(REG_INTR_CLR, w);
        check_value("intr status", 0, w);

        // whole palette via auto-increment
        bus_write_word(REG_XR_ADDR, XR_PAL_BASE);
        for (int i = 0; i < 256; i++) begin
            color        = 12'($urandom);
            pal_model[i] = color;
            bus_write_word(REG_XR_DATA, {4'h0, color});
        end
        base_model = int'($urandom_range(255, 1));
        bus_write_word(REG_XR_ADDR, XR_VID_BASE);
        bus_write_word(REG_XR_DATA, 16'(base_model));
        wait_cycles(4);                     // base reaches the pixel pipe
        pix_on = 1'b1;

        // vblank interrupt, masked in
        bus_write_word(REG_INTR_CLR, 16'h0003);
        bus_write_word(REG_INTR_MASK, 16'(1 << INTR_VBLANK));
        wait_for_intr(intr_count, seen);
        expect_true(seen, "no vblank interrupt within a frame");
        p1 = last_intr_cyc;
        bus_read_word(REG_INTR_CLR, w);
        check_value("vblank status", 1, int'(w[INTR_VBLANK]));
        n0 = intr_count;
        wait_cycles(FRAME + 10);            // pending, so the next vblank is silent
        check_value("intr pulses while pending", n0, intr_count);
        bus_write_word(REG_INTR_CLR, 16'h0003);
        bus_read_word(REG_INTR_CLR, w);
        check_value("status after clear", 0, w);
        wait_for_intr(intr_count, seen);
        expect_true(seen, "no vblank interrupt after clear");
        check_value("vblank pulse spacing", 2 * FRAME, last_intr_cyc - p1);

        // line compare, vblank masked out
        bus_write_word(REG_XR_ADDR, XR_LINE_CMP);
        bus_write_word(REG_XR_DATA, 16'd20);
        bus_write_word(REG_INTR_MASK, 16'(1 << INTR_LINE));
        bus_write_word(REG_INTR_CLR, 16'h0003);
        n0 = intr_count;
        wait_for_intr(n0, seen);
        expect_true(seen, "no line interrupt within a frame");
        bus_read_word(REG_SCANLINE, w);
        expect_true(w == 20 || w == 21, $sformatf("scanline %0d after line 20 interrupt", w));
        wait_cycles((V_VISIBLE - 20 + 2) * H_TOTAL);
        check_value("intr pulses with vblank masked", n0 + 1, intr_count);
        bus_read_word(REG_INTR_CLR, w);
        check_value("status with vblank masked", 3, w);

        // scanline reads at random times
        repeat (16) begin
            wait_cycles(int'($urandom_range(150, 1)));
            bus_read_word(REG_SCANLINE, w);
            expect_true(w < V_TOTAL, $sformatf("scanline %0d out of range", w));
        end

        $display("checks done: %0d value errors, %0d other errors", err_value, err_other);
        if (err_value + err_other == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: vid_top.f
+incdir+testbench
src/vid_pkg.sv
src/bus_regs.sv
src/palette_ram.sv
src/video_timing.sv
src/intr_ctrl.sv
src/vid_top.sv
testbench/vid_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the video core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal \
    -f vid_top.f \
    --top-module vid_top_tb \
    -o vid_sim

./obj_dir/vid_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi

if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"
